// ==== rs_pkg.sv ====
`default_nettype none

package rs_pkg;

    // datapath widths
    localparam int DATA_W   = 32;
    localparam int ADDR_W   = 32;
    localparam int TAG_W    = 4;
    localparam int SHAMT_W  = 5;
    localparam int OPENUM_W = 6;

    // station depth
    localparam int RS_SIZE  = 4;
    localparam int RS_IDX_W = $clog2(RS_SIZE);

    // one instruction word, for the link address
    localparam int INSN_BYTES = 4;

    typedef logic [DATA_W-1:0]   data_t;
    typedef logic [ADDR_W-1:0]   addr_t;
    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [SHAMT_W-1:0]  shamt_t;
    typedef logic [RS_IDX_W-1:0] rs_idx_t;

    // tag 0 marks an operand that is already present
    localparam tag_t TAG_NONE = '0;

    typedef enum logic [OPENUM_W-1:0] {
        OP_NOP,
        LUI,
        AUIPC,
        JAL,
        JALR,
        BEQ,
        BNE,
        BLT,
        BGE,
        BLTU,
        BGEU,
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND,
        ADDI,
        SLLI,
        SLTI,
        SLTIU,
        XORI,
        SRLI,
        SRAI,
        ORI,
        ANDI
    } openum_e;

endpackage

`default_nettype wire

// ==== cdb_if.sv ====
`default_nettype none

// one common data bus broadcast
interface cdb_if;

    logic           valid;
    rs_pkg::tag_t   tag;
    rs_pkg::data_t  result;
    rs_pkg::addr_t  target_pc;
    logic           jump_flag;

    modport source (
        output valid, tag, result, target_pc, jump_flag
    );

    modport sink (
        input valid, tag, result, target_pc, jump_flag
    );

endinterface

`default_nettype wire

// ==== rs_ex.sv ====
`default_nettype none

module rs_ex (
    input  wire rs_pkg::openum_e openum,
    input  wire rs_pkg::data_t   v1,
    input  wire rs_pkg::data_t   v2,
    input  wire rs_pkg::data_t   imm,
    input  wire rs_pkg::addr_t   pc,

    output rs_pkg::data_t        result,
    output rs_pkg::addr_t        target_pc,
    output logic                 jump_flag,
    output logic                 valid
);

    // only the low bits shift, as in RV32I
    rs_pkg::shamt_t shamt_r;
    rs_pkg::shamt_t shamt_i;
    rs_pkg::addr_t  link_pc;
    rs_pkg::addr_t  branch_pc;

    assign shamt_r   = v2[rs_pkg::SHAMT_W-1:0];
    assign shamt_i   = imm[rs_pkg::SHAMT_W-1:0];
    assign link_pc   = pc + rs_pkg::addr_t'(rs_pkg::INSN_BYTES);
    assign branch_pc = pc + imm;

    always_comb begin
        valid     = (openum != rs_pkg::OP_NOP);
        result    = '0;
        target_pc = '0;
        jump_flag = 1'b0;
        case (openum)
            rs_pkg::LUI:   result = imm;
            rs_pkg::AUIPC: result = pc + imm;
            rs_pkg::JAL: begin
                result    = link_pc;
                target_pc = branch_pc;
                jump_flag = 1'b1;
            end
            rs_pkg::JALR: begin
                result    = link_pc;
                target_pc = v1 + imm;
                jump_flag = 1'b1;
            end
            rs_pkg::BEQ: begin
                target_pc = branch_pc;
                jump_flag = (v1 == v2);
            end
            rs_pkg::BNE: begin
                target_pc = branch_pc;
                jump_flag = (v1 != v2);
            end
            rs_pkg::BLT: begin
                target_pc = branch_pc;
                jump_flag = ($signed(v1) < $signed(v2));
            end
            rs_pkg::BGE: begin
                target_pc = branch_pc;
                jump_flag = ($signed(v1) >= $signed(v2));
            end
            rs_pkg::BLTU: begin
                target_pc = branch_pc;
                jump_flag = (v1 < v2);
            end
            rs_pkg::BGEU: begin
                target_pc = branch_pc;
                jump_flag = (v1 >= v2);
            end
            // register operand
            rs_pkg::ADD:   result = v1 + v2;
            rs_pkg::SUB:   result = v1 - v2;
            rs_pkg::SLL:   result = v1 << shamt_r;
            rs_pkg::SLT:   result = rs_pkg::data_t'($signed(v1) < $signed(v2));
            rs_pkg::SLTU:  result = rs_pkg::data_t'(v1 < v2);
            rs_pkg::XOR:   result = v1 ^ v2;
            rs_pkg::SRL:   result = v1 >> shamt_r;
            rs_pkg::SRA:   result = rs_pkg::data_t'($signed(v1) >>> shamt_r);
            rs_pkg::OR:    result = v1 | v2;
            rs_pkg::AND:   result = v1 & v2;
            // immediate operand
            rs_pkg::ADDI:  result = v1 + imm;
            rs_pkg::SLLI:  result = v1 << shamt_i;
            rs_pkg::SLTI:  result = rs_pkg::data_t'($signed(v1) < $signed(imm));
            rs_pkg::SLTIU: result = rs_pkg::data_t'(v1 < imm);
            rs_pkg::XORI:  result = v1 ^ imm;
            rs_pkg::SRLI:  result = v1 >> shamt_i;
            rs_pkg::SRAI:  result = rs_pkg::data_t'($signed(v1) >>> shamt_i);
            rs_pkg::ORI:   result = v1 | imm;
            rs_pkg::ANDI:  result = v1 & imm;
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== rs_entries.sv ====
`default_nettype none

module rs_entries (
    input  wire                  clk,
    input  wire                  reset,

    input  wire                  issue_valid,
    input  wire rs_pkg::openum_e issue_op,
    input  wire rs_pkg::data_t   issue_v1,
    input  wire rs_pkg::data_t   issue_v2,
    input  wire rs_pkg::data_t   issue_imm,
    input  wire rs_pkg::tag_t    issue_q1,
    input  wire rs_pkg::tag_t    issue_q2,
    input  wire rs_pkg::tag_t    issue_dest,
    input  wire rs_pkg::addr_t   issue_pc,
    output logic                 full,

    cdb_if.sink                  cdb,

    output rs_pkg::openum_e      ex_op,
    output rs_pkg::data_t        ex_v1,
    output rs_pkg::data_t        ex_v2,
    output rs_pkg::data_t        ex_imm,
    output rs_pkg::addr_t        ex_pc,
    output rs_pkg::tag_t         ex_dest
);

    logic [rs_pkg::RS_SIZE-1:0] busy;
    rs_pkg::openum_e            ent_op   [rs_pkg::RS_SIZE];
    rs_pkg::data_t              ent_v1   [rs_pkg::RS_SIZE];
    rs_pkg::data_t              ent_v2   [rs_pkg::RS_SIZE];
    rs_pkg::data_t              ent_imm  [rs_pkg::RS_SIZE];
    rs_pkg::tag_t               ent_q1   [rs_pkg::RS_SIZE];
    rs_pkg::tag_t               ent_q2   [rs_pkg::RS_SIZE];
    rs_pkg::tag_t               ent_dest [rs_pkg::RS_SIZE];
    rs_pkg::addr_t              ent_pc   [rs_pkg::RS_SIZE];

    rs_pkg::rs_idx_t free_idx;
    rs_pkg::rs_idx_t ready_idx;
    logic            ready_found;
    logic            do_issue;

    // captured issue operands, woken in the same cycle if the bus matches
    rs_pkg::data_t   cap_v1;
    rs_pkg::data_t   cap_v2;
    rs_pkg::tag_t    cap_q1;
    rs_pkg::tag_t    cap_q2;

    function automatic logic cdb_hit(rs_pkg::tag_t q);
        return cdb.valid && (q != rs_pkg::TAG_NONE) && (q == cdb.tag);
    endfunction

    assign full     = &busy;
    assign do_issue = issue_valid && !full;

    // lowest free entry
    always_comb begin
        free_idx = '0;
        for (int i = rs_pkg::RS_SIZE - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                free_idx = rs_pkg::rs_idx_t'(i);
            end
        end
    end

    // lowest entry with both operands present
    always_comb begin
        ready_found = 1'b0;
        ready_idx   = '0;
        for (int i = rs_pkg::RS_SIZE - 1; i >= 0; i--) begin
            if (busy[i] && ent_q1[i] == rs_pkg::TAG_NONE &&
                    ent_q2[i] == rs_pkg::TAG_NONE) begin
                ready_found = 1'b1;
                ready_idx   = rs_pkg::rs_idx_t'(i);
            end
        end
    end

    assign cap_v1 = cdb_hit(issue_q1) ? cdb.result : issue_v1;
    assign cap_v2 = cdb_hit(issue_q2) ? cdb.result : issue_v2;
    assign cap_q1 = cdb_hit(issue_q1) ? rs_pkg::TAG_NONE : issue_q1;
    assign cap_q2 = cdb_hit(issue_q2) ? rs_pkg::TAG_NONE : issue_q2;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= '0;
        end else begin
            for (int i = 0; i < rs_pkg::RS_SIZE; i++) begin
                if (ready_found && ready_idx == rs_pkg::rs_idx_t'(i)) begin
                    busy[i] <= 1'b0;
                end
            end
            if (do_issue) begin
                busy[free_idx] <= 1'b1;
            end
        end
    end

    // entry payload and operand wakeup
    always_ff @(posedge clk) begin
        for (int i = 0; i < rs_pkg::RS_SIZE; i++) begin
            if (do_issue && free_idx == rs_pkg::rs_idx_t'(i)) begin
                ent_op[i]   <= issue_op;
                ent_v1[i]   <= cap_v1;
                ent_v2[i]   <= cap_v2;
                ent_q1[i]   <= cap_q1;
                ent_q2[i]   <= cap_q2;
                ent_imm[i]  <= issue_imm;
                ent_dest[i] <= issue_dest;
                ent_pc[i]   <= issue_pc;
            end else if (busy[i]) begin
                if (cdb_hit(ent_q1[i])) begin
                    ent_v1[i] <= cdb.result;
                    ent_q1[i] <= rs_pkg::TAG_NONE;
                end
                if (cdb_hit(ent_q2[i])) begin
                    ent_v2[i] <= cdb.result;
                    ent_q2[i] <= rs_pkg::TAG_NONE;
                end
            end
        end
    end

    // dispatch register, NOP when nothing is ready
    always_ff @(posedge clk) begin
        if (reset) begin
            ex_op <= rs_pkg::OP_NOP;
        end else if (ready_found) begin
            ex_op <= ent_op[ready_idx];
        end else begin
            ex_op <= rs_pkg::OP_NOP;
        end
    end

    always_ff @(posedge clk) begin
        if (ready_found) begin
            ex_v1   <= ent_v1[ready_idx];
            ex_v2   <= ent_v2[ready_idx];
            ex_imm  <= ent_imm[ready_idx];
            ex_pc   <= ent_pc[ready_idx];
            ex_dest <= ent_dest[ready_idx];
        end
    end

endmodule

`default_nettype wire

// ==== rs_top.sv ====
`default_nettype none

module rs_top (
    input  wire                  clk,
    input  wire                  reset,

    input  wire                  issue_valid,
    input  wire rs_pkg::openum_e issue_op,
    input  wire rs_pkg::data_t   issue_v1,
    input  wire rs_pkg::data_t   issue_v2,
    input  wire rs_pkg::data_t   issue_imm,
    input  wire rs_pkg::tag_t    issue_q1,
    input  wire rs_pkg::tag_t    issue_q2,
    input  wire rs_pkg::tag_t    issue_dest,
    input  wire rs_pkg::addr_t   issue_pc,

    input  wire                  ext_cdb_valid,
    input  wire rs_pkg::tag_t    ext_cdb_tag,
    input  wire rs_pkg::data_t   ext_cdb_result,

    output logic                 full,
    output logic                 cdb_valid,
    output rs_pkg::tag_t         cdb_tag,
    output rs_pkg::data_t        cdb_result,
    output rs_pkg::addr_t        cdb_target_pc,
    output logic                 cdb_jump_flag
);

    rs_pkg::openum_e ex_op;
    rs_pkg::data_t   ex_v1;
    rs_pkg::data_t   ex_v2;
    rs_pkg::data_t   ex_imm;
    rs_pkg::addr_t   ex_pc;
    rs_pkg::tag_t    ex_dest;

    cdb_if cdb_own ();
    cdb_if cdb_bus ();

    rs_entries i_entries (
        .clk         (clk),
        .reset       (reset),
        .issue_valid (issue_valid),
        .issue_op    (issue_op),
        .issue_v1    (issue_v1),
        .issue_v2    (issue_v2),
        .issue_imm   (issue_imm),
        .issue_q1    (issue_q1),
        .issue_q2    (issue_q2),
        .issue_dest  (issue_dest),
        .issue_pc    (issue_pc),
        .full        (full),
        .cdb         (cdb_bus.sink),
        .ex_op       (ex_op),
        .ex_v1       (ex_v1),
        .ex_v2       (ex_v2),
        .ex_imm      (ex_imm),
        .ex_pc       (ex_pc),
        .ex_dest     (ex_dest)
    );

    rs_ex i_ex (
        .openum    (ex_op),
        .v1        (ex_v1),
        .v2        (ex_v2),
        .imm       (ex_imm),
        .pc        (ex_pc),
        .result    (cdb_own.result),
        .target_pc (cdb_own.target_pc),
        .jump_flag (cdb_own.jump_flag),
        .valid     (cdb_own.valid)
    );

    assign cdb_own.tag = ex_dest;

    // own broadcast wins, external one carries no target or jump
    assign cdb_bus.valid     = cdb_own.valid | ext_cdb_valid;
    assign cdb_bus.tag       = cdb_own.valid ? cdb_own.tag : ext_cdb_tag;
    assign cdb_bus.result    = cdb_own.valid ? cdb_own.result : ext_cdb_result;
    assign cdb_bus.target_pc = cdb_own.valid ? cdb_own.target_pc : '0;
    assign cdb_bus.jump_flag = cdb_own.valid & cdb_own.jump_flag;

    assign cdb_valid     = cdb_own.valid;
    assign cdb_tag       = cdb_own.tag;
    assign cdb_result    = cdb_own.result;
    assign cdb_target_pc = cdb_own.target_pc;
    assign cdb_jump_flag = cdb_own.jump_flag;

endmodule

`default_nettype wire

// ==== rs_top_sva.sv ====
`default_nettype none

module rs_top_sva (
    input wire clk,
    input wire reset,
    input wire issue_valid,
    input wire full,
    input wire ext_cdb_valid,
    input wire cdb_valid,
    input wire cdb_jump_flag
);

    timeunit 1ns;
    timeprecision 1ps;

    int failures = 0;

    // issuer keeps off a full station
    a_no_issue_when_full: assert property (
        @(posedge clk) disable iff (reset) !(issue_valid && full)
    ) else begin
        failures++;
        $error("issue_valid asserted while full is high");
    end

    // one broadcast per cycle on the merged bus
    a_no_cdb_overlap: assert property (
        @(posedge clk) disable iff (reset) !(cdb_valid && ext_cdb_valid)
    ) else begin
        failures++;
        $error("own and external broadcasts in the same cycle");
    end

    a_jump_needs_valid: assert property (
        @(posedge clk) disable iff (reset) cdb_jump_flag |-> cdb_valid
    ) else begin
        failures++;
        $error("cdb_jump_flag high without cdb_valid");
    end

    // dispatch register holds a NOP right after reset
    a_idle_after_reset: assert property (
        @(posedge clk) reset |=> !cdb_valid
    ) else begin
        failures++;
        $error("cdb_valid high in the cycle after reset");
    end

endmodule

bind rs_top rs_top_sva i_sva (.*);

`default_nettype wire

// ==== tb_rs_top.sv ====
`default_nettype none

module tb_rs_top;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT_CYCLES = 20;

    typedef struct {
        rs_pkg::openum_e op;
        rs_pkg::data_t   v1;
        rs_pkg::data_t   v2;
        rs_pkg::data_t   imm;
        rs_pkg::addr_t   pc;
        rs_pkg::data_t   result;
        rs_pkg::addr_t   target_pc;
        logic            jump_flag;
    } row_t;

    logic            clk;
    logic            reset;
    logic            issue_valid;
    rs_pkg::openum_e issue_op;
    rs_pkg::data_t   issue_v1;
    rs_pkg::data_t   issue_v2;
    rs_pkg::data_t   issue_imm;
    rs_pkg::tag_t    issue_q1;
    rs_pkg::tag_t    issue_q2;
    rs_pkg::tag_t    issue_dest;
    rs_pkg::addr_t   issue_pc;
    logic            ext_cdb_valid;
    rs_pkg::tag_t    ext_cdb_tag;
    rs_pkg::data_t   ext_cdb_result;
    logic            full;
    logic            cdb_valid;
    rs_pkg::tag_t    cdb_tag;
    rs_pkg::data_t   cdb_result;
    rs_pkg::addr_t   cdb_target_pc;
    logic            cdb_jump_flag;

    row_t rows[$];

    rs_top i_dut (.*);

    always begin
        #20 clk = ~clk;
    end

    // a failed bound assertion ends the run at once
    always @(i_dut.i_sva.failures) begin
        if (i_dut.i_sva.failures != 0) begin
            give_up("a bound assertion failed");
        end
    end

    // expected outputs of one operation under the RV32I rules
    function automatic row_t model_row(rs_pkg::openum_e op, rs_pkg::data_t v1,
                                       rs_pkg::data_t v2, rs_pkg::data_t imm,
                                       rs_pkg::addr_t pc);
        row_t          r;
        rs_pkg::data_t b;
        r = '{op, v1, v2, imm, pc, 0, 0, 0};
        b = (op >= rs_pkg::ADDI) ? imm : v2;
        case (op)
            rs_pkg::LUI:                 r.result = imm;
            rs_pkg::AUIPC:               r.result = pc + imm;
            rs_pkg::JAL:                 r.target_pc = pc + imm;
            rs_pkg::JALR:                r.target_pc = v1 + imm;
            rs_pkg::BEQ:                 r.jump_flag = (v1 == v2);
            rs_pkg::BNE:                 r.jump_flag = (v1 != v2);
            rs_pkg::BLT:                 r.jump_flag = ($signed(v1) < $signed(v2));
            rs_pkg::BGE:                 r.jump_flag = !($signed(v1) < $signed(v2));
            rs_pkg::BLTU:                r.jump_flag = (v1 < v2);
            rs_pkg::BGEU:                r.jump_flag = !(v1 < v2);
            rs_pkg::ADD, rs_pkg::ADDI:   r.result = v1 + b;
            rs_pkg::SUB:                 r.result = v1 - b;
            rs_pkg::SLL, rs_pkg::SLLI:   r.result = v1 << b[4:0];
            rs_pkg::SLT, rs_pkg::SLTI:   r.result = {31'd0, $signed(v1) < $signed(b)};
            rs_pkg::SLTU, rs_pkg::SLTIU: r.result = {31'd0, v1 < b};
            rs_pkg::XOR, rs_pkg::XORI:   r.result = v1 ^ b;
            rs_pkg::SRL, rs_pkg::SRLI:   r.result = v1 >> b[4:0];
            rs_pkg::SRA, rs_pkg::SRAI:   r.result = $signed(v1) >>> b[4:0];
            rs_pkg::OR, rs_pkg::ORI:     r.result = v1 | b;
            rs_pkg::AND, rs_pkg::ANDI:   r.result = v1 & b;
            default: ;
        endcase
        // jumps link to the next instruction
        if (op == rs_pkg::JAL || op == rs_pkg::JALR) begin
            r.result    = pc + 32'd4;
            r.jump_flag = 1'b1;
        end
        if (op >= rs_pkg::BEQ && op <= rs_pkg::BGEU) begin
            r.target_pc = pc + imm;
        end
        return r;
    endfunction

    task automatic check(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            $display("Checks failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic give_up(string why);
        $display("%s at %0t ns", why, $time);
        $display("Checks failed");
        $fatal(1, "run aborted");
    endtask

    task automatic issue(rs_pkg::openum_e op, rs_pkg::data_t v1, rs_pkg::data_t v2,
                         rs_pkg::data_t imm, rs_pkg::addr_t pc, rs_pkg::tag_t q1,
                         rs_pkg::tag_t q2, rs_pkg::tag_t dest);
        issue_valid = 1'b1;
        issue_op    = op;
        issue_v1    = v1;
        issue_v2    = v2;
        issue_imm   = imm;
        issue_pc    = pc;
        issue_q1    = q1;
        issue_q2    = q2;
        issue_dest  = dest;
        @(negedge clk);
        issue_valid = 1'b0;
    endtask

    task automatic broadcast(rs_pkg::tag_t tag, rs_pkg::data_t value);
        ext_cdb_valid  = 1'b1;
        ext_cdb_tag    = tag;
        ext_cdb_result = value;
        @(negedge clk);
        ext_cdb_valid  = 1'b0;
    endtask

    // edges counted from the falling edge where the wait starts
    task automatic await_result(output int edges);
        edges = 0;
        while (!cdb_valid && edges < TIMEOUT_CYCLES) begin
            @(negedge clk);
            edges++;
        end
        if (!cdb_valid) begin
            give_up("no cdb_valid within the timeout");
        end
    endtask

    initial begin
        rs_pkg::openum_e op;
        rs_pkg::tag_t    dest;
        int              edges;
        void'($urandom(32'h85bc));
        clk            = 1'b0;
        reset          = 1'b1;
        issue_valid    = 1'b0;
        issue_op       = rs_pkg::OP_NOP;
        issue_v1       = '0;
        issue_v2       = '0;
        issue_imm      = '0;
        issue_pc       = '0;
        issue_q1       = '0;
        issue_q2       = '0;
        issue_dest     = '0;
        ext_cdb_valid  = 1'b0;
        ext_cdb_tag    = '0;
        ext_cdb_result = '0;

        // branches taken and not taken and a few corner cases
        rows.push_back('{rs_pkg::BEQ, 5, 5, 'h20, 'h100, 0, 'h120, 1});
        rows.push_back('{rs_pkg::BEQ, 5, 6, 'h20, 'h100, 0, 'h120, 0});
        rows.push_back('{rs_pkg::BNE, 5, 6, 'h20, 'h100, 0, 'h120, 1});
        rows.push_back('{rs_pkg::BNE, 7, 7, 'h20, 'h100, 0, 'h120, 0});
        rows.push_back('{rs_pkg::BLT, 'hffffffff, 1, 'h20, 'h100, 0, 'h120, 1});
        rows.push_back('{rs_pkg::BLT, 1, 'hffffffff, 'h20, 'h100, 0, 'h120, 0});
        rows.push_back('{rs_pkg::BGE, 1, 'hffffffff, 'h20, 'h100, 0, 'h120, 1});
        rows.push_back('{rs_pkg::BGE, 'hffffffff, 1, 'h20, 'h100, 0, 'h120, 0});
        rows.push_back('{rs_pkg::BLTU, 1, 'hffffffff, 'h20, 'h100, 0, 'h120, 1});
        rows.push_back('{rs_pkg::BLTU, 'hffffffff, 1, 'h20, 'h100, 0, 'h120, 0});
        rows.push_back('{rs_pkg::BGEU, 'hffffffff, 1, 'h20, 'h100, 0, 'h120, 1});
        rows.push_back('{rs_pkg::BGEU, 1, 'hffffffff, 'h20, 'h100, 0, 'h120, 0});
        rows.push_back('{rs_pkg::JALR, 'h1000, 0, 'h8, 'h200, 'h204, 'h1008, 1});
        rows.push_back('{rs_pkg::SRA, 'h80000000, 'h24, 0, 'h0, 'hf8000000, 0, 0});
        // one random row per operation
        for (int k = 1; k <= int'(rs_pkg::ANDI); k++) begin
            op = rs_pkg::openum_e'(k);
            rows.push_back(model_row(op, $urandom, $urandom, $urandom,
                                     $urandom & 32'hffff_fffc));
        end

        repeat (3) @(negedge clk);
        reset = 1'b0;
        check("cdb_valid", cdb_valid, 0);
        check("cdb_jump_flag", cdb_jump_flag, 0);
        check("full", full, 0);

        // a NOP leaves the bus quiet
        issue(rs_pkg::OP_NOP, 0, 0, 0, 0, 0, 0, 4'd1);
        repeat (3) begin
            check("cdb_valid", cdb_valid, 0);
            @(negedge clk);
        end

        foreach (rows[i]) begin
            dest = rs_pkg::tag_t'(i % 15 + 1);
            issue(rows[i].op, rows[i].v1, rows[i].v2, rows[i].imm, rows[i].pc, 0, 0, dest);
            await_result(edges);
            check("issue-to-result edges", edges + 1, 2);
            check("cdb_tag", cdb_tag, dest);
            check("cdb_result", cdb_result, rows[i].result);
            check("cdb_target_pc", cdb_target_pc, rows[i].target_pc);
            check("cdb_jump_flag", cdb_jump_flag, rows[i].jump_flag);
        end

        // first operand waits on an external unit
        issue(rs_pkg::ADD, 0, 32'd10, 0, 'h40, 4'd5, 0, 4'd3);
        repeat (4) begin
            check("cdb_valid", cdb_valid, 0);
            @(negedge clk);
        end
        broadcast(4'd5, 32'h1234);
        await_result(edges);
        check("cdb_tag", cdb_tag, 3);
        check("cdb_result", cdb_result, 32'h123e);

        // B consumes A through the station's own broadcast
        issue(rs_pkg::ADDI, 32'd100, 0, 32'd5, 'h80, 0, 0, 4'd7);
        issue(rs_pkg::ADD, 0, 32'd1, 0, 'h84, 4'd7, 0, 4'd8);
        await_result(edges);
        check("cdb_tag", cdb_tag, 7);
        check("cdb_result", cdb_result, 105);
        @(negedge clk);
        await_result(edges);
        check("cdb_tag", cdb_tag, 8);
        check("cdb_result", cdb_result, 106);

        // fill the station on one missing tag
        for (int k = 0; k < rs_pkg::RS_SIZE; k++) begin
            issue(rs_pkg::ADD, 0, k, 0, 'hc0, 4'd9, 0, rs_pkg::tag_t'(10 + k));
        end
        check("full", full, 1);
        broadcast(4'd9, 32'h50);
        for (int k = 0; k < rs_pkg::RS_SIZE; k++) begin
            await_result(edges);
            check("cdb_tag", cdb_tag, 10 + k);
            check("cdb_result", cdb_result, 32'h50 + k);
            @(negedge clk);
        end
        check("full", full, 0);

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
rs_pkg.sv
cdb_if.sv
rs_ex.sv
rs_entries.sv
rs_top.sv
rs_top_sva.sv
tb_rs_top.sv

// ==== Bender.yml ====
package:
  name: rs_top

sources:
  - rs_pkg.sv
  - cdb_if.sv
  - rs_ex.sv
  - rs_entries.sv
  - rs_top.sv
  - target: test
    files:
      - rs_top_sva.sv
      - tb_rs_top.sv
